// ==== common/sd_pkg.sv ====
`default_nettype none

package sd_pkg;

    typedef logic [31:0]  sd_word_t;
    typedef logic [5:0]   sd_cmd_index_t;
    // counted in sd clock periods
    typedef logic [15:0]  sd_timeout_t;
    typedef logic [7:0]   sd_divisor_t;
    typedef logic [3:0]   sd_reg_addr_t;
    typedef logic [119:0] sd_resp_long_t;
    typedef logic [4:0]   sd_int_status_t;

    typedef enum logic [1:0] {
        RESP_NONE  = 2'd0,
        RESP_SHORT = 2'd1,
        RESP_LONG  = 2'd2
    } sd_resp_type_e;

    // command as issued by the host
    typedef struct packed {
        sd_cmd_index_t index;
        sd_resp_type_e resp_type;
        sd_word_t      argument;
    } sd_cmd_req_t;

    // no_resp is high while the host waits for a start bit
    typedef struct packed {
        sd_resp_long_t payload;
        logic          crc_err;
        logic          index_err;
        logic          no_resp;
    } sd_cmd_result_t;

    // word addresses on the host bus
    localparam sd_reg_addr_t REG_ARGUMENT   = 4'd0;
    localparam sd_reg_addr_t REG_COMMAND    = 4'd1;
    localparam sd_reg_addr_t REG_TIMEOUT    = 4'd2;
    localparam sd_reg_addr_t REG_DIVISOR    = 4'd3;
    localparam sd_reg_addr_t REG_INT_STATUS = 4'd4;
    localparam sd_reg_addr_t REG_INT_ENABLE = 4'd5;
    localparam sd_reg_addr_t REG_RESP0      = 4'd6;
    localparam sd_reg_addr_t REG_RESP1      = 4'd7;
    localparam sd_reg_addr_t REG_RESP2      = 4'd8;
    localparam sd_reg_addr_t REG_RESP3      = 4'd9;

    // command interrupt status bits
    localparam int INT_CC   = 0;
    localparam int INT_EI   = 1;
    localparam int INT_CTE  = 2;
    localparam int INT_CCRC = 3;
    localparam int INT_CIE  = 4;

    localparam int CMD_FRAME_BITS  = 48;
    localparam int RESP_SHORT_BITS = 48;
    localparam int RESP_LONG_BITS  = 136;

endpackage

`default_nettype wire

// ==== verilog/sd_clock_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_clock_divider (
    input  wire logic                wb_clk_i,
    input  wire logic                rst_n_i,
    input  wire sd_pkg::sd_divisor_t divisor_i,
    output logic                     sd_clk_o,
    output logic                     sd_strobe_o
);
    import sd_pkg::*;

    sd_divisor_t cnt_q;
    // divisor in use, reloaded at each toggle
    sd_divisor_t div_q;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            cnt_q       <= '0;
            div_q       <= divisor_i;
            sd_clk_o    <= 1'b0;
            sd_strobe_o <= 1'b0;
        end else begin
            sd_strobe_o <= 1'b0;
            if (cnt_q == div_q) begin
                cnt_q       <= '0;
                div_q       <= divisor_i;
                sd_clk_o    <= ~sd_clk_o;
                // strobe lines up with the rising edge
                sd_strobe_o <= ~sd_clk_o;
            end else begin
                cnt_q <= cnt_q + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sd_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_regs #(
    parameter sd_pkg::sd_divisor_t DEFAULT_DIVISOR = 8'd2
) (
    input  wire logic                   wb_clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   wb_cyc_i,
    input  wire logic                   wb_stb_i,
    input  wire logic                   wb_we_i,
    input  wire sd_pkg::sd_reg_addr_t   wb_adr_i,
    input  wire sd_pkg::sd_word_t       wb_dat_i,
    output sd_pkg::sd_word_t            wb_dat_o,
    output logic                        wb_ack_o,
    output logic                        cmd_start_o,
    output sd_pkg::sd_cmd_req_t         cmd_req_o,
    output sd_pkg::sd_timeout_t         cmd_timeout_o,
    output logic                        int_clear_o,
    output sd_pkg::sd_divisor_t         divisor_o,
    input  wire sd_pkg::sd_int_status_t int_status_i,
    input  wire sd_pkg::sd_resp_long_t  resp_i,
    input  wire logic                   busy_i,
    output logic                        interrupt_o
);
    import sd_pkg::*;

    sd_word_t       argument_q;
    sd_cmd_index_t  cmd_index_q;
    sd_resp_type_e  cmd_resp_q;
    sd_int_status_t int_enable_q;
    sd_word_t       rd_data;
    logic           wb_req;
    logic           wb_wr;

    // new request seen while ack is still low
    assign wb_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wb_wr  = wb_req && wb_we_i;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            wb_ack_o      <= 1'b0;
            cmd_start_o   <= 1'b0;
            int_clear_o   <= 1'b0;
            argument_q    <= '0;
            cmd_index_q   <= '0;
            cmd_resp_q    <= RESP_NONE;
            cmd_timeout_o <= '0;
            divisor_o     <= DEFAULT_DIVISOR;
            int_enable_q  <= '0;
        end else begin
            wb_ack_o    <= wb_req;
            cmd_start_o <= 1'b0;
            int_clear_o <= 1'b0;
            if (wb_wr) begin
                case (wb_adr_i)
                    REG_ARGUMENT: argument_q <= wb_dat_i;
                    REG_COMMAND: begin
                        // ignored while a command is in flight
                        if (!busy_i) begin
                            cmd_index_q <= wb_dat_i[5:0];
                            cmd_resp_q  <= sd_resp_type_e'(wb_dat_i[9:8]);
                            cmd_start_o <= 1'b1;
                        end
                    end
                    REG_TIMEOUT:    cmd_timeout_o <= wb_dat_i[15:0];
                    REG_DIVISOR:    divisor_o     <= wb_dat_i[7:0];
                    REG_INT_STATUS: int_clear_o   <= 1'b1;
                    REG_INT_ENABLE: int_enable_q  <= wb_dat_i[4:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        cmd_req_o.index     = cmd_index_q;
        cmd_req_o.resp_type = cmd_resp_q;
        cmd_req_o.argument  = argument_q;
    end

    always_comb begin
        case (wb_adr_i)
            REG_ARGUMENT:   rd_data = argument_q;
            REG_COMMAND:    rd_data = {22'd0, cmd_resp_q, 2'd0, cmd_index_q};
            REG_TIMEOUT:    rd_data = sd_word_t'(cmd_timeout_o);
            REG_DIVISOR:    rd_data = sd_word_t'(divisor_o);
            REG_INT_STATUS: rd_data = sd_word_t'(int_status_i);
            REG_INT_ENABLE: rd_data = sd_word_t'(int_enable_q);
            REG_RESP0:      rd_data = resp_i[31:0];
            REG_RESP1:      rd_data = resp_i[63:32];
            REG_RESP2:      rd_data = resp_i[95:64];
            REG_RESP3:      rd_data = sd_word_t'(resp_i[119:96]);
            default:        rd_data = '0;
        endcase
    end

    // read data captured together with the ack
    always_ff @(posedge wb_clk_i) begin
        if (wb_req) begin
            wb_dat_o <= rd_data;
        end
    end

    assign interrupt_o = |(int_status_i & int_enable_q);

    // the bus master must hold stb until it sees the ack
    a_ack_with_stb: assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i) wb_ack_o |-> wb_stb_i
    ) else $error("wishbone ack without stb");

endmodule

`default_nettype wire

// ==== cmd/sd_cmd_serial_host.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_serial_host (
    input  wire logic                wb_clk_i,
    input  wire logic                rst_n_i,
    input  wire logic                sd_strobe_i,
    input  wire logic                xfr_start_i,
    input  wire sd_pkg::sd_cmd_req_t xfr_req_i,
    input  wire logic                xfr_abort_i,
    output logic                     xfr_done_o,
    output sd_pkg::sd_cmd_result_t   xfr_result_o,
    input  wire logic                sd_cmd_i,
    output logic                     sd_cmd_o,
    output logic                     sd_cmd_oe_o
);
    import sd_pkg::*;

    typedef enum logic [2:0] {IDLE, TX, WAIT_START, RX, FINISH} state_e;

    // bits covered by crc7 in a command or short response
    localparam int CRC_SPAN = CMD_FRAME_BITS - 8;

    state_e        state_q;
    sd_cmd_req_t   req_q;
    logic [127:0]  shift_q;
    logic [7:0]    bit_cnt_q;
    logic [6:0]    crc_q;
    logic [7:0]    resp_len;
    sd_resp_long_t payload_q;
    logic          crc_err_q;
    logic          index_err_q;

    // x^7 + x^3 + 1
    function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic din);
        logic fb;
        fb = din ^ crc[6];
        return {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    endfunction

    assign resp_len = (req_q.resp_type == RESP_LONG) ? 8'(RESP_LONG_BITS)
                                                     : 8'(RESP_SHORT_BITS);

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            sd_cmd_o    <= 1'b1;
            sd_cmd_oe_o <= 1'b0;
            xfr_done_o  <= 1'b0;
            bit_cnt_q   <= '0;
            crc_q       <= '0;
            crc_err_q   <= 1'b0;
            index_err_q <= 1'b0;
        end else if (xfr_abort_i) begin
            state_q     <= IDLE;
            sd_cmd_o    <= 1'b1;
            sd_cmd_oe_o <= 1'b0;
            xfr_done_o  <= 1'b0;
        end else begin
            xfr_done_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (xfr_start_i) begin
                        req_q            <= xfr_req_i;
                        // start bit, direction bit, index, argument
                        shift_q[127:88]  <= {2'b01, xfr_req_i.index, xfr_req_i.argument};
                        bit_cnt_q        <= '0;
                        crc_q            <= '0;
                        state_q          <= TX;
                    end
                end
                TX: begin
                    if (sd_strobe_i) begin
                        bit_cnt_q   <= bit_cnt_q + 8'd1;
                        sd_cmd_oe_o <= 1'b1;
                        if (bit_cnt_q < CRC_SPAN) begin
                            sd_cmd_o <= shift_q[127];
                            shift_q  <= {shift_q[126:0], 1'b0};
                            crc_q    <= crc7_step(crc_q, shift_q[127]);
                        end else if (bit_cnt_q < CMD_FRAME_BITS - 1) begin
                            sd_cmd_o <= crc_q[6];
                            crc_q    <= {crc_q[5:0], 1'b0};
                        end else if (bit_cnt_q == CMD_FRAME_BITS - 1) begin
                            sd_cmd_o <= 1'b1;
                        end else begin
                            // end bit held one period, release the line
                            sd_cmd_oe_o <= 1'b0;
                            bit_cnt_q   <= '0;
                            crc_q       <= '0;
                            state_q     <= (req_q.resp_type == RESP_NONE) ? FINISH : WAIT_START;
                        end
                    end
                end
                WAIT_START: begin
                    if (sd_strobe_i && !sd_cmd_i) begin
                        shift_q   <= {shift_q[126:0], 1'b0};
                        bit_cnt_q <= 8'd1;
                        state_q   <= RX;
                    end
                end
                RX: begin
                    if (sd_strobe_i) begin
                        shift_q   <= {shift_q[126:0], sd_cmd_i};
                        bit_cnt_q <= bit_cnt_q + 8'd1;
                        if (bit_cnt_q < CRC_SPAN) begin
                            crc_q <= crc7_step(crc_q, sd_cmd_i);
                        end
                        if (bit_cnt_q == resp_len - 8'd1) begin
                            state_q <= FINISH;
                        end
                    end
                end
                FINISH: begin
                    xfr_done_o  <= 1'b1;
                    payload_q   <= '0;
                    crc_err_q   <= 1'b0;
                    index_err_q <= 1'b0;
                    if (req_q.resp_type == RESP_LONG) begin
                        // cid/csd without the crc byte
                        payload_q <= shift_q[127:8];
                    end else if (req_q.resp_type != RESP_NONE) begin
                        payload_q[31:0] <= shift_q[39:8];
                        crc_err_q       <= (crc_q != shift_q[7:1]);
                        index_err_q     <= (shift_q[45:40] != req_q.index);
                    end
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_comb begin
        xfr_result_o.payload   = payload_q;
        xfr_result_o.crc_err   = crc_err_q;
        xfr_result_o.index_err = index_err_q;
        xfr_result_o.no_resp   = (state_q == WAIT_START);
    end

    // the card owns the line from the end bit until the response is in
    a_oe_low_in_rx: assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i)
        (state_q inside {WAIT_START, RX}) |-> !sd_cmd_oe_o
    ) else $error("command line driven while receiving");

endmodule

`default_nettype wire

// ==== cmd/sd_cmd_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_master (
    input  wire logic                   wb_clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   sd_strobe_i,
    input  wire logic                   cmd_start_i,
    input  wire sd_pkg::sd_cmd_req_t    cmd_req_i,
    input  wire sd_pkg::sd_timeout_t    cmd_timeout_i,
    input  wire logic                   int_clear_i,
    output sd_pkg::sd_int_status_t      int_status_o,
    output sd_pkg::sd_resp_long_t       resp_o,
    output logic                        busy_o,
    output logic                        xfr_start_o,
    output sd_pkg::sd_cmd_req_t         xfr_req_o,
    output logic                        xfr_abort_o,
    input  wire logic                   xfr_done_i,
    input  wire sd_pkg::sd_cmd_result_t xfr_result_i
);
    import sd_pkg::*;

    typedef enum logic [1:0] {IDLE, SEND, WAIT} state_e;

    // timeout completes the command with an error
    localparam sd_int_status_t TMO_BITS =
        sd_int_status_t'((1 << INT_CC) | (1 << INT_EI) | (1 << INT_CTE));

    state_e         state_q;
    sd_timeout_t    tmo_cnt_q;
    sd_int_status_t status_base;
    sd_int_status_t done_bits;

    always_comb begin
        // a clear in the same cycle as a new event keeps the event
        status_base = int_clear_i ? '0 : int_status_o;

        done_bits           = '0;
        done_bits[INT_CC]   = 1'b1;
        done_bits[INT_EI]   = xfr_result_i.crc_err || xfr_result_i.index_err;
        done_bits[INT_CCRC] = xfr_result_i.crc_err;
        done_bits[INT_CIE]  = xfr_result_i.index_err;
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            tmo_cnt_q    <= '0;
            int_status_o <= '0;
            resp_o       <= '0;
            xfr_start_o  <= 1'b0;
            xfr_abort_o  <= 1'b0;
        end else begin
            xfr_start_o  <= 1'b0;
            xfr_abort_o  <= 1'b0;
            int_status_o <= status_base;
            case (state_q)
                IDLE: begin
                    if (cmd_start_i) begin
                        xfr_req_o   <= cmd_req_i;
                        xfr_start_o <= 1'b1;
                        tmo_cnt_q   <= '0;
                        state_q     <= SEND;
                    end
                end
                SEND: begin
                    // done here only for commands without a response
                    if (xfr_done_i) begin
                        int_status_o <= status_base | done_bits;
                        state_q      <= IDLE;
                    end else if (xfr_result_i.no_resp) begin
                        state_q <= WAIT;
                    end
                end
                WAIT: begin
                    if (xfr_done_i) begin
                        resp_o       <= xfr_result_i.payload;
                        int_status_o <= status_base | done_bits;
                        state_q      <= IDLE;
                    end else if (sd_strobe_i && xfr_result_i.no_resp) begin
                        if (tmo_cnt_q + 16'd1 >= cmd_timeout_i) begin
                            xfr_abort_o  <= 1'b1;
                            int_status_o <= status_base | TMO_BITS;
                            state_q      <= IDLE;
                        end else begin
                            tmo_cnt_q <= tmo_cnt_q + 16'd1;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign busy_o = (state_q != IDLE);

    // register block must hold off new commands while one is running
    a_no_start_busy: assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i) cmd_start_i |-> !busy_o
    ) else $error("command start while busy");

endmodule

`default_nettype wire

// ==== verilog/sd_emmc_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_emmc_controller #(
    parameter sd_pkg::sd_divisor_t DEFAULT_DIVISOR = 8'd2
) (
    input  wire logic                 wb_clk_i,
    input  wire logic                 rst_n_i,
    input  wire logic                 wb_cyc_i,
    input  wire logic                 wb_stb_i,
    input  wire logic                 wb_we_i,
    input  wire sd_pkg::sd_reg_addr_t wb_adr_i,
    input  wire sd_pkg::sd_word_t     wb_dat_i,
    output sd_pkg::sd_word_t          wb_dat_o,
    output logic                      wb_ack_o,
    output logic                      sd_clk_o,
    output logic                      sd_cmd_o,
    output logic                      sd_cmd_oe_o,
    input  wire logic                 sd_cmd_i,
    output logic                      interrupt_o
);
    import sd_pkg::*;

    sd_divisor_t    divisor;
    logic           sd_strobe;
    logic           cmd_start;
    sd_cmd_req_t    cmd_req;
    sd_timeout_t    cmd_timeout;
    logic           int_clear;
    sd_int_status_t int_status;
    sd_resp_long_t  resp;
    logic           busy;

    // between command master and serial host
    logic           xfr_start;
    sd_cmd_req_t    xfr_req;
    logic           xfr_abort;
    logic           xfr_done;
    sd_cmd_result_t xfr_result;

    sd_regs #(
        .DEFAULT_DIVISOR(DEFAULT_DIVISOR)
    ) u_regs (
        .wb_clk_i     (wb_clk_i),
        .rst_n_i      (rst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .cmd_start_o  (cmd_start),
        .cmd_req_o    (cmd_req),
        .cmd_timeout_o(cmd_timeout),
        .int_clear_o  (int_clear),
        .divisor_o    (divisor),
        .int_status_i (int_status),
        .resp_i       (resp),
        .busy_i       (busy),
        .interrupt_o  (interrupt_o)
    );

    sd_clock_divider u_clock_divider (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .divisor_i  (divisor),
        .sd_clk_o   (sd_clk_o),
        .sd_strobe_o(sd_strobe)
    );

    sd_cmd_master u_cmd_master (
        .wb_clk_i     (wb_clk_i),
        .rst_n_i      (rst_n_i),
        .sd_strobe_i  (sd_strobe),
        .cmd_start_i  (cmd_start),
        .cmd_req_i    (cmd_req),
        .cmd_timeout_i(cmd_timeout),
        .int_clear_i  (int_clear),
        .int_status_o (int_status),
        .resp_o       (resp),
        .busy_o       (busy),
        .xfr_start_o  (xfr_start),
        .xfr_req_o    (xfr_req),
        .xfr_abort_o  (xfr_abort),
        .xfr_done_i   (xfr_done),
        .xfr_result_i (xfr_result)
    );

    sd_cmd_serial_host u_cmd_serial_host (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .sd_strobe_i (sd_strobe),
        .xfr_start_i (xfr_start),
        .xfr_req_i   (xfr_req),
        .xfr_abort_i (xfr_abort),
        .xfr_done_o  (xfr_done),
        .xfr_result_o(xfr_result),
        .sd_cmd_i    (sd_cmd_i),
        .sd_cmd_o    (sd_cmd_o),
        .sd_cmd_oe_o (sd_cmd_oe_o)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 10 ns bus clock
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset held over the first five rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/tb_sd_emmc_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sd_emmc_controller;
    import sd_pkg::*;

    localparam sd_divisor_t DEFAULT_DIVISOR = 8'd2;
    localparam sd_divisor_t FRAME_DIVISOR   = 8'd3;
    localparam int          CLK_PERIOD_NS   = 10;
    localparam logic [31:0] SEED            = 32'd93640;
    localparam sd_timeout_t CMD_TIMEOUT     = 16'd24;
    localparam int          NUM_CMDS        = 6;
    // bus cycles allowed per command at the slowest sd clock
    localparam int          CMD_BUDGET      = 2500;
    // two spare budgets cover the register tests
    localparam int          WATCHDOG_CYCLES = (NUM_CMDS + 2) * CMD_BUDGET;

    localparam int CARD_OK        = 0;
    localparam int CARD_BAD_CRC   = 1;
    localparam int CARD_BAD_INDEX = 2;
    localparam int CARD_SILENT    = 3;

    logic          clk;
    logic          rst_n;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    sd_reg_addr_t  wb_adr;
    sd_word_t      wb_dat_w;
    sd_word_t      wb_dat_r;
    logic          wb_ack;
    logic          sd_clk;
    logic          sd_cmd;
    logic          sd_cmd_oe;
    logic          sd_cmd_in;
    logic          irq;

    logic [31:0]   lfsr_q = SEED;
    logic          rd_chk;
    sd_word_t      exp_rd;
    logic          irq_chk;
    logic          exp_irq;
    logic [47:0]   exp_frame;
    longint        exp_period;
    sd_resp_long_t exp_resp;

    // card model state
    int            card_mode;
    logic          card_long;
    sd_word_t      card_status;
    logic [127:0]  long_body;
    logic [47:0]   rx_frame = '0;
    int            frame_cnt = 0;
    longint        sd_period = 0;
    longint        last_rise = 0;

    tb_clock_gen u_clock_gen (
        .clk_o  (clk),
        .rst_n_o(rst_n)
    );

    sd_emmc_controller #(
        .DEFAULT_DIVISOR(DEFAULT_DIVISOR)
    ) dut (
        .wb_clk_i   (clk),
        .rst_n_i    (rst_n),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_we_i    (wb_we),
        .wb_adr_i   (wb_adr),
        .wb_dat_i   (wb_dat_w),
        .wb_dat_o   (wb_dat_r),
        .wb_ack_o   (wb_ack),
        .sd_clk_o   (sd_clk),
        .sd_cmd_o   (sd_cmd),
        .sd_cmd_oe_o(sd_cmd_oe),
        .sd_cmd_i   (sd_cmd_in),
        .interrupt_o(irq)
    );

    task automatic report_mismatch(input string sig, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("SIMULATION FAILED");
        $display("mismatch at %0t: %s expected 0x%0h, actual 0x%0h",
                 $time, sig, expected, actual);
        $fatal(1);
    endtask

    // x^7 + x^3 + 1 over the 40 bits ahead of the crc field
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        int         i;
        crc = '0;
        for (i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    // fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [127:0] random_bits(input int n);
        logic [127:0] v;
        int           k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[126:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic bus_cycle(input logic we, input sd_reg_addr_t adr, input sd_word_t dat,
                             input logic chk, input sd_word_t expected);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        rd_chk   <= chk;
        exp_rd   <= expected;
        @(posedge clk);
        while (!wb_ack) begin
            @(posedge clk);
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        rd_chk <= 1'b0;
    endtask

    task automatic write_reg(input sd_reg_addr_t adr, input sd_word_t dat);
        bus_cycle(1'b1, adr, dat, 1'b0, '0);
    endtask

    task automatic read_expect(input sd_reg_addr_t adr, input sd_word_t expected);
        bus_cycle(1'b0, adr, '0, 1'b1, expected);
    endtask

    task automatic check_irq(input logic expected);
        @(posedge clk);
        exp_irq <= expected;
        irq_chk <= 1'b1;
        @(posedge clk);
        irq_chk <= 1'b0;
    endtask

    task automatic check_resp();
        read_expect(REG_RESP0, exp_resp[31:0]);
        read_expect(REG_RESP1, exp_resp[63:32]);
        read_expect(REG_RESP2, exp_resp[95:64]);
        read_expect(REG_RESP3, {8'd0, exp_resp[119:96]});
    endtask

    task automatic run_command(input sd_cmd_index_t idx, input sd_resp_type_e rtype,
                               input int mode, input sd_int_status_t exp_status);
        sd_word_t     arg;
        sd_word_t     status;
        logic [127:0] lbody;
        logic [39:0]  body;
        int           frames;
        arg      = sd_word_t'(random_bits(32));
        status   = sd_word_t'(random_bits(32));
        lbody    = random_bits(128);
        lbody[0] = 1'b1;
        body     = {2'b01, idx, arg};
        if (mode != CARD_SILENT && rtype == RESP_SHORT) begin
            exp_resp = sd_resp_long_t'(status);
        end else if (mode != CARD_SILENT && rtype == RESP_LONG) begin
            exp_resp = lbody[127:8];
        end
        exp_frame   <= {body, crc7_of(body), 1'b1};
        card_mode   <= mode;
        card_long   <= (rtype == RESP_LONG);
        card_status <= status;
        long_body   <= lbody;
        write_reg(REG_INT_STATUS, '0);
        write_reg(REG_ARGUMENT, arg);
        frames = frame_cnt;
        write_reg(REG_COMMAND, {22'd0, rtype, 2'd0, idx});
        // command complete raises the interrupt
        @(posedge clk);
        while (!irq) begin
            @(posedge clk);
        end
        // every command puts exactly one frame on the line
        assert (frame_cnt == frames + 1)
            else report_mismatch("sd_cmd_o frame count", 64'(frames + 1), 64'(frame_cnt));
        read_expect(REG_INT_STATUS, sd_word_t'(exp_status));
    endtask

    always @(posedge sd_clk) begin
        sd_period <= longint'($time) - last_rise;
        last_rise = longint'($time);
    end

    // card side of the command line
    initial begin : card_model
        logic [47:0]   frame;
        logic [135:0]  resp;
        logic [39:0]   body;
        logic [6:0]    crc;
        sd_cmd_index_t idx;
        int            nbits;
        int            i;
        sd_cmd_in = 1'b1;
        forever begin
            @(posedge sd_clk);
            if (sd_cmd_oe && !sd_cmd) begin
                frame = '0;
                for (i = 0; i < 47; i++) begin
                    @(posedge sd_clk);
                    frame = {frame[46:0], sd_cmd};
                end
                rx_frame  <= frame;
                frame_cnt <= frame_cnt + 1;
                if (card_mode != CARD_SILENT) begin
                    idx = frame[45:40];
                    if (card_mode == CARD_BAD_INDEX) begin
                        idx = idx ^ 6'h01;
                    end
                    if (card_long) begin
                        resp  = {2'b00, 6'h3f, long_body};
                        nbits = RESP_LONG_BITS;
                    end else begin
                        body = {2'b00, idx, card_status};
                        crc  = crc7_of(body);
                        if (card_mode == CARD_BAD_CRC) begin
                            crc = crc ^ 7'h01;
                        end
                        resp  = {body, crc, 1'b1, 88'd0};
                        nbits = RESP_SHORT_BITS;
                    end
                    repeat (2) @(negedge sd_clk);
                    for (i = 0; i < nbits; i++) begin
                        sd_cmd_in <= resp[135];
                        resp = resp << 1;
                        @(negedge sd_clk);
                    end
                    sd_cmd_in <= 1'b1;
                end
            end
        end
    end

    a_reset_outputs: assert property (
        @(posedge clk) $rose(rst_n) |-> ({wb_ack, irq, sd_cmd_oe, sd_cmd} == 4'b0001)
    ) else report_mismatch("reset outputs", 64'h1, 64'({wb_ack, irq, sd_cmd_oe, sd_cmd}));

    a_ack_timing: assert property (
        @(posedge clk) disable iff (!rst_n) (wb_cyc && wb_stb && !wb_ack) |=> wb_ack
    ) else report_mismatch("wb_ack_o", 64'h1, 64'(wb_ack));

    a_read_data: assert property (
        @(posedge clk) disable iff (!rst_n) (wb_ack && rd_chk) |-> (wb_dat_r == exp_rd)
    ) else report_mismatch("wb_dat_o", 64'(exp_rd), 64'(wb_dat_r));

    a_frame: assert property (
        @(posedge clk) disable iff (!rst_n) $changed(frame_cnt) |-> (rx_frame == exp_frame)
    ) else report_mismatch("sd_cmd_o frame", 64'(exp_frame), 64'(rx_frame));

    a_sd_period: assert property (
        @(posedge clk) disable iff (!rst_n) $changed(frame_cnt) |-> (sd_period == exp_period)
    ) else report_mismatch("sd_clk_o period", 64'(exp_period), 64'(sd_period));

    a_irq: assert property (
        @(posedge clk) disable iff (!rst_n) irq_chk |-> (irq == exp_irq)
    ) else report_mismatch("interrupt_o", 64'(exp_irq), 64'(irq));

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("SIMULATION FAILED");
        $display("watchdog expired after %0d cycles before the tests finished",
                 WATCHDOG_CYCLES);
        $fatal(1);
    end

    initial begin : stimulus
        int       a;
        sd_word_t v;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        rd_chk     = 1'b0;
        exp_rd     = '0;
        irq_chk    = 1'b0;
        exp_irq    = 1'b0;
        exp_frame  = '0;
        exp_resp   = '0;
        exp_period = 2 * (FRAME_DIVISOR + 1) * CLK_PERIOD_NS;
        card_mode  = CARD_SILENT;
        card_long  = 1'b0;
        @(posedge clk);
        while (!rst_n) begin
            @(posedge clk);
        end

        // reset values and readback
        for (a = 0; a < 10; a++) begin
            read_expect(sd_reg_addr_t'(a), (a == REG_DIVISOR) ? 32'(DEFAULT_DIVISOR) : 32'd0);
        end
        v = sd_word_t'(random_bits(32));
        write_reg(REG_ARGUMENT, v);
        read_expect(REG_ARGUMENT, v);
        v = sd_word_t'(random_bits(16));
        write_reg(REG_TIMEOUT, v);
        read_expect(REG_TIMEOUT, v);
        write_reg(REG_DIVISOR, 32'(FRAME_DIVISOR));
        read_expect(REG_DIVISOR, 32'(FRAME_DIVISOR));
        write_reg(REG_INT_ENABLE, 32'h1f);
        read_expect(REG_INT_ENABLE, 32'h1f);
        write_reg(REG_TIMEOUT, 32'(CMD_TIMEOUT));

        // frame on a slower sd clock without a response
        run_command(6'd0, RESP_NONE, CARD_SILENT, 5'b00001);
        write_reg(REG_DIVISOR, 32'(DEFAULT_DIVISOR));
        exp_period <= 2 * (DEFAULT_DIVISOR + 1) * CLK_PERIOD_NS;

        run_command(6'd13, RESP_SHORT, CARD_OK, 5'b00001);
        check_resp();
        check_irq(1'b1);
        run_command(6'd17, RESP_SHORT, CARD_BAD_CRC, 5'b01011);
        run_command(6'd17, RESP_SHORT, CARD_BAD_INDEX, 5'b10011);
        // response words keep the last payload on a timeout
        run_command(6'd13, RESP_SHORT, CARD_SILENT, 5'b00111);
        check_resp();

        run_command(6'd2, RESP_LONG, CARD_OK, 5'b00001);
        check_resp();
        check_irq(1'b1);
        write_reg(REG_INT_STATUS, '0);
        check_irq(1'b0);
        read_expect(REG_INT_STATUS, '0);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
common/sd_pkg.sv
verilog/sd_clock_divider.sv
verilog/sd_regs.sv
cmd/sd_cmd_serial_host.sv
cmd/sd_cmd_master.sv
verilog/sd_emmc_controller.sv
sim/tb_clock_gen.sv
sim/tb_sd_emmc_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator and run, exit status follows the simulation
cd "$(dirname "$0")" \
    && verilator --binary --assert -Wno-fatal --top-module tb_sd_emmc_controller \
        -f list.f -o tb_sim \
    && ./obj_dir/tb_sim \
    || exit 1
